//--- Makefile
VERILATOR ?= verilator
TOP       ?= dstTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qx "Testbench passed" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
verilog/dstPkg.sv
verilog/dbgMuxSel.sv
verilog/traceCtrl.sv
verilog/timestampCounter.sv
verilog/traceBuffer.sv
verilog/dstRegs.sv
verilog/dstTop.sv
tests/tbClock.sv
tests/dstTb.sv

//--- tests/dstTb.sv
// Testbench for the trace unit with cycle model, APB checks and watchdog
`timescale 1ns/1ps
`default_nettype none

module dstTb import dstPkg::*; ();

  localparam int CLK_PERIOD      = 100;
  localparam int WATCHDOG_CYCLES = 20000;
  localparam int SEED            = 48264;
  localparam int PULSE_START     = 0;
  localparam int PULSE_STOP      = 1;
  localparam int PULSE_TRACE     = 2;

  logic                                       clk;
  logic                                       rstN;
  logic [NUM_HW_WORDS-1:0][HW_WORD_WIDTH-1:0] hw;
  logic                                       timeTick;
  logic                                       traceStart;
  logic                                       traceStop;
  logic                                       tracePulse;
  logic [APB_ADDR_WIDTH-1:0]                  paddr;
  logic                                       psel;
  logic                                       penable;
  logic                                       pwrite;
  logic [APB_DATA_WIDTH-1:0]                  pwdata;
  logic                                       pready;
  logic [APB_DATA_WIDTH-1:0]                  prdata;
  logic                                       pslverr;

  int errorCount;
  int checkCount;
  int testCount;
  int testErrStart;

  // Reference model state
  logic                       mEnable;
  logic                       mWrapMode;
  logic [LANE_SEL_WIDTH-1:0]  mSel0;
  logic [LANE_SEL_WIDTH-1:0]  mSel1;
  logic [DEBUG_BUS_WIDTH-1:0] mBus;
  logic                       mChanged;
  traceState_e                mState;
  logic                       mFirst;
  logic [TSTAMP_WIDTH-1:0]    mTstamp;
  logic [PTR_WIDTH-1:0]       mPtr;
  logic                       mWrapped;
  logic [DEBUG_BUS_WIDTH-1:0] mData [TRACE_DEPTH];
  logic [TSTAMP_WIDTH-1:0]    mTs   [TRACE_DEPTH];
  int                         mCapCount;

  tbClock uClock (.o_clk(clk));

  dstTop dut (
    .i_clk(clk), .i_rstN(rstN), .i_hw(hw), .i_timeTick(timeTick),
    .i_traceStart(traceStart), .i_traceStop(traceStop), .i_tracePulse(tracePulse),
    .i_paddr(paddr), .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
    .i_pwdata(pwdata), .o_pready(pready), .o_prdata(prdata), .o_pslverr(pslverr)
  );

  // ************************************************************
  // Cycle model stepping from the pre-edge view
  // ************************************************************
  always @(posedge clk) begin : modelStep
    logic        cap;
    logic        clr;
    traceState_e nxt;
    if (!rstN) begin
      mEnable   <= 1'b0;
      mWrapMode <= 1'b0;
      mSel0     <= '0;
      mSel1     <= '0;
      mBus      <= '0;
      mChanged  <= 1'b0;
      mState    <= ST_IDLE;
      mFirst    <= 1'b0;
      mTstamp   <= '0;
      mPtr      <= '0;
      mWrapped  <= 1'b0;
      mCapCount <= 0;
    end else begin
      clr = mEnable && (mState == ST_ARMED) && traceStart;
      // A full buffer in stop mode takes nothing more
      cap = (mWrapMode || !mWrapped) &&
            (((mState == ST_TRACING) && (mFirst || mChanged)) ||
             (tracePulse && (mState == ST_ARMED || mState == ST_TRACING)));
      nxt = mState;
      if (!mEnable) begin
        nxt = ST_IDLE;
      end else begin
        case (mState)
          ST_IDLE:    nxt = ST_ARMED;
          ST_ARMED:   if (traceStart) nxt = ST_TRACING;
          ST_TRACING: begin
            if (traceStop) nxt = ST_ARMED;
            else if (!mWrapMode && mWrapped) nxt = ST_FULL;
          end
          default:    if (traceStop) nxt = ST_ARMED;
        endcase
      end
      mState <= nxt;
      mFirst <= clr;
      if (clr) begin
        mPtr      <= '0;
        mWrapped  <= 1'b0;
        mTstamp   <= '0;
        mCapCount <= 0;
      end else begin
        if (cap) begin
          mData[mPtr] <= mBus;
          mTs[mPtr]   <= mTstamp;
          mPtr        <= mPtr + 4'd1;
          mCapCount   <= mCapCount + 1;
          if (mPtr == 4'd15) mWrapped <= 1'b1;
        end
        if (timeTick) mTstamp <= mTstamp + 16'd1;
      end
      mChanged <= ({hw[mSel1], hw[mSel0]} != mBus);
      mBus     <= {hw[mSel1], hw[mSel0]};
      if (psel && penable && pwrite) begin
        if (paddr == REG_CTRL) begin
          mEnable   <= pwdata[0];
          mWrapMode <= pwdata[1];
        end
        if (paddr == REG_MUXSEL) begin
          mSel0 <= pwdata[3:0];
          mSel1 <= pwdata[7:4];
        end
      end
    end
  end

  // Expected read data from the register map
  function automatic logic [31:0] modelRead(input logic [APB_ADDR_WIDTH-1:0] addr);
    logic [APB_ADDR_WIDTH-1:0] offset;
    offset = addr - BUF_WINDOW_BASE;
    case (addr)
      REG_CTRL:   return {30'd0, mWrapMode, mEnable};
      REG_MUXSEL: return {24'd0, mSel1, mSel0};
      REG_STATUS: return {20'd0, mPtr, 5'd0, mWrapped, mState};
      REG_TSTAMP: return {16'd0, mTstamp};
      default:    return offset[2] ? {16'd0, mTs[offset[6:3]]} : mData[offset[6:3]];
    endcase
  endfunction

  // ************************************************************
  // Checks and bus tasks
  // ************************************************************
  task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
    checkCount++;
    assert (got === exp) else begin
      errorCount++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic apbAccess(input logic [APB_ADDR_WIDTH-1:0] addr, input logic write,
                           input logic [31:0] wdata, input logic expErr,
                           output logic [31:0] rdata);
    @(posedge clk);
    #1;
    paddr   = addr;
    pwdata  = wdata;
    pwrite  = write;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    rdata = prdata;
    checkValue(32'(pready), 32'd1, "pready");
    checkValue(32'(pslverr), 32'(expErr), $sformatf("pslverr at %h", addr));
    if (!write && !expErr) checkValue(prdata, modelRead(addr), $sformatf("read %h", addr));
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apbWrite(input logic [APB_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                          input logic expErr);
    logic [31:0] unused;
    apbAccess(addr, 1'b1, data, expErr, unused);
  endtask

  task automatic apbRead(input logic [APB_ADDR_WIDTH-1:0] addr, input logic expErr,
                         output logic [31:0] data);
    apbAccess(addr, 1'b0, 32'd0, expErr, data);
  endtask

  task automatic waitCycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic pulseInput(input int which);
    @(posedge clk);
    #1;
    traceStart = (which == PULSE_START);
    traceStop  = (which == PULSE_STOP);
    tracePulse = (which == PULSE_TRACE);
    @(posedge clk);
    #1;
    traceStart = 1'b0;
    traceStop  = 1'b0;
    tracePulse = 1'b0;
  endtask

  task automatic waitForState(input traceState_e st, input int maxPolls);
    logic [31:0] status;
    int          polls;
    polls = 0;
    do begin
      apbRead(REG_STATUS, 1'b0, status);
      polls++;
    end while (status[1:0] != st && polls < maxPolls);
    assert (status[1:0] == st) else begin
      errorCount++;
      $display("trace state %s not reached after %0d status reads", st.name(), polls);
    end
  endtask

  task automatic readAllEntries();
    logic [31:0] data;
    for (int i = 0; i < 2 * TRACE_DEPTH; i++) begin
      apbRead(BUF_WINDOW_BASE + 12'(4 * i), 1'b0, data);
    end
  endtask

  task automatic endTest(input string name);
    testCount++;
    $display("test %0d %s: %0d errors", testCount, name, errorCount - testErrStart);
    testErrStart = errorCount;
  endtask

  // Hardware words hold for 1 to 4 cycles and ticks come at random
  initial begin : hwStimulus
    int holdCycles;
    hw         = '0;
    timeTick   = 1'b0;
    holdCycles = 1;
    forever begin
      @(posedge clk);
      #1;
      timeTick = 1'($urandom_range(1, 0));
      holdCycles--;
      if (holdCycles == 0) begin
        for (int i = 0; i < NUM_HW_WORDS; i++) begin
          hw[i] = 16'($urandom());
        end
        holdCycles = int'($urandom_range(4, 1));
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  // ************************************************************
  // Test sequence
  // ************************************************************
  initial begin : mainSeq
    logic [31:0]          rd;
    logic [31:0]          val;
    logic [PTR_WIDTH-1:0] ptrHold;
    int                   waited;
    void'($urandom(SEED));
    errorCount   = 0;
    checkCount   = 0;
    testCount    = 0;
    testErrStart = 0;
    rstN         = 1'b0;
    traceStart   = 1'b0;
    traceStop    = 1'b0;
    tracePulse   = 1'b0;
    paddr        = '0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    pwdata       = '0;
    repeat (4) @(posedge clk);
    #1;
    rstN = 1'b1;

    apbRead(REG_STATUS, 1'b0, rd);
    checkValue(rd, 32'd0, "status after reset");
    val = $urandom();
    apbWrite(REG_CTRL, val, 1'b0);
    apbRead(REG_CTRL, 1'b0, rd);
    checkValue(rd, val & 32'h3, "ctrl readback");
    val = $urandom();
    apbWrite(REG_MUXSEL, val, 1'b0);
    apbRead(REG_MUXSEL, 1'b0, rd);
    checkValue(rd, val & 32'hFF, "muxsel readback");
    apbRead(12'h010, 1'b1, rd);
    apbWrite(REG_STATUS, 32'hFFFF_FFFF, 1'b1);
    apbWrite(REG_CTRL, 32'd0, 1'b0);
    endTest("register access");

    apbWrite(REG_MUXSEL, {24'd0, 8'($urandom())}, 1'b0);
    apbWrite(REG_CTRL, 32'h1, 1'b0);
    waitForState(ST_ARMED, 10);
    pulseInput(PULSE_START);
    waitForState(ST_FULL, 100);
    readAllEntries();
    endTest("stop mode capture");

    apbWrite(REG_CTRL, 32'h3, 1'b0);
    pulseInput(PULSE_STOP);
    waitForState(ST_ARMED, 10);
    pulseInput(PULSE_START);
    waited = 0;
    while (mCapCount < 3 * TRACE_DEPTH / 2 && waited < 500) begin
      waitCycles(1);
      waited++;
    end
    assert (mCapCount >= 3 * TRACE_DEPTH / 2) else begin
      errorCount++;
      $display("too few captures in wrap mode after %0d cycles", waited);
    end
    pulseInput(PULSE_STOP);
    waitForState(ST_ARMED, 10);
    apbRead(REG_STATUS, 1'b0, rd);
    checkValue(32'(rd[2]), 32'd1, "wrapped flag");
    readAllEntries();
    endTest("wrap mode capture");

    apbRead(REG_STATUS, 1'b0, rd);
    ptrHold = mPtr;
    waitCycles(12);
    apbRead(REG_STATUS, 1'b0, rd);
    checkValue(32'(rd[11:8]), 32'(ptrHold), "pointer while armed");
    pulseInput(PULSE_TRACE);
    apbRead(REG_STATUS, 1'b0, rd);
    checkValue(32'(rd[11:8]), 32'(4'(ptrHold + 4'd1)), "pointer after pulse");
    apbRead(BUF_WINDOW_BASE + 12'(8 * ptrHold), 1'b0, rd);
    apbRead(BUF_WINDOW_BASE + 12'(8 * ptrHold + 4), 1'b0, rd);
    endTest("armed pulse");

    apbWrite(REG_CTRL, 32'h0, 1'b0);
    waitForState(ST_IDLE, 10);
    apbRead(REG_STATUS, 1'b0, rd);
    ptrHold = mPtr;
    pulseInput(PULSE_START);
    pulseInput(PULSE_TRACE);
    apbRead(REG_TSTAMP, 1'b0, rd);
    waitCycles(8);
    apbRead(REG_TSTAMP, 1'b0, rd);
    apbRead(REG_STATUS, 1'b0, rd);
    checkValue(32'(rd[11:8]), 32'(ptrHold), "pointer while idle");
    endTest("disabled trace");

    $display("tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/tbClock.sv
// Free-running testbench clock
`timescale 1ns/1ps
`default_nettype none

module tbClock (
  output logic o_clk
);

  localparam int HALF_PERIOD = 50;

  initial begin
    o_clk = 1'b0;
    forever #(HALF_PERIOD) o_clk = ~o_clk;
  end

endmodule

`default_nettype wire

//--- verilog/dbgMuxSel.sv
// Debug bus lane select register with change detection
`timescale 1ns/1ps
`default_nettype none

module dbgMuxSel import dstPkg::*; (
  input  logic                                         i_clk,
  input  logic                                         i_rstN,
  input  logic [NUM_HW_WORDS-1:0][HW_WORD_WIDTH-1:0]   i_hw,
  input  logic [LANE_SEL_WIDTH-1:0]                    i_laneSel0,
  input  logic [LANE_SEL_WIDTH-1:0]                    i_laneSel1,
  output logic [DEBUG_BUS_WIDTH-1:0]                   o_debugBus,
  output logic                                         o_busChanged
);

  logic [DEBUG_BUS_WIDTH-1:0] selBus;
  logic [DEBUG_BUS_WIDTH-1:0] busQ;
  logic [DEBUG_BUS_WIDTH-1:0] prevBusQ;

  // Lane 1 in the upper half
  assign selBus = {i_hw[i_laneSel1], i_hw[i_laneSel0]};

  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      busQ     <= '0;
      prevBusQ <= '0;
    end else begin
      busQ     <= selBus;
      prevBusQ <= busQ;
    end
  end

  assign o_debugBus   = busQ;
  // High for one cycle after a new value was loaded
  assign o_busChanged = (busQ != prevBusQ);

endmodule

`default_nettype wire

//--- verilog/dstPkg.sv
// Shared sizes, APB register offsets and trace state encoding
`default_nettype none

package dstPkg;

  // ************************************************************
  // Widths and depths
  // ************************************************************
  localparam int HW_WORD_WIDTH   = 16;
  localparam int NUM_HW_WORDS    = 16;
  localparam int LANE_SEL_WIDTH  = 4;
  // Two lanes side by side
  localparam int DEBUG_BUS_WIDTH = 2 * HW_WORD_WIDTH;
  localparam int TSTAMP_WIDTH    = 16;
  localparam int TRACE_DEPTH     = 16;
  localparam int PTR_WIDTH       = 4;

  // APB
  localparam int APB_ADDR_WIDTH  = 12;
  localparam int APB_DATA_WIDTH  = 32;

  // Entry i: data at base + 8*i, timestamp 4 bytes above
  localparam logic [APB_ADDR_WIDTH-1:0] BUF_WINDOW_BASE = 12'h100;

  // ************************************************************
  // Register map and states
  // ************************************************************
  typedef enum logic [APB_ADDR_WIDTH-1:0] {
    REG_CTRL   = 12'h000,
    REG_MUXSEL = 12'h004,
    REG_STATUS = 12'h008,
    REG_TSTAMP = 12'h00C
  } regAddr_e;

  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_ARMED   = 2'd1,
    ST_TRACING = 2'd2,
    ST_FULL    = 2'd3
  } traceState_e;

endpackage

`default_nettype wire

//--- verilog/dstRegs.sv
// APB slave with control, mux-select, status and trace buffer read window
`timescale 1ns/1ps
`default_nettype none

module dstRegs import dstPkg::*; (
  input  logic                      i_clk,
  input  logic                      i_rstN,
  input  logic [APB_ADDR_WIDTH-1:0] i_paddr,
  input  logic                      i_psel,
  input  logic                      i_penable,
  input  logic                      i_pwrite,
  input  logic [APB_DATA_WIDTH-1:0] i_pwdata,
  input  traceState_e               i_state,
  input  logic [PTR_WIDTH-1:0]      i_wrPtr,
  input  logic                      i_wrapped,
  input  logic [TSTAMP_WIDTH-1:0]   i_tstamp,
  input  logic [APB_DATA_WIDTH-1:0] i_bufData,
  output logic                      o_pready,
  output logic [APB_DATA_WIDTH-1:0] o_prdata,
  output logic                      o_pslverr,
  output logic                      o_enable,
  output logic                      o_wrapMode,
  output logic [LANE_SEL_WIDTH-1:0] o_laneSel0,
  output logic [LANE_SEL_WIDTH-1:0] o_laneSel1,
  output logic [PTR_WIDTH-1:0]      o_bufRdIdx,
  output logic                      o_bufRdHalf
);

  logic                      access;
  logic                      bufHit;
  logic [APB_ADDR_WIDTH-1:0] bufOffset;
  logic                      regHit;
  logic                      regWritable;
  logic [APB_DATA_WIDTH-1:0] rdData;

  // Zero wait state, response valid in the access cycle
  assign access   = i_psel & i_penable;
  assign o_pready = access;

  // ************************************************************
  // Buffer window decode
  // ************************************************************
  assign bufOffset   = i_paddr - BUF_WINDOW_BASE;
  assign bufHit      = (i_paddr >= BUF_WINDOW_BASE) &&
                       (i_paddr < (BUF_WINDOW_BASE + 12'(TRACE_DEPTH * 8)));
  assign o_bufRdIdx  = bufOffset[PTR_WIDTH+2:3];
  assign o_bufRdHalf = bufOffset[2];

  // Register decode and read mux
  always_comb begin
    regHit      = 1'b1;
    regWritable = 1'b0;
    rdData      = '0;
    case (i_paddr)
      REG_CTRL: begin
        regWritable = 1'b1;
        rdData      = {30'd0, o_wrapMode, o_enable};
      end
      REG_MUXSEL: begin
        regWritable = 1'b1;
        rdData      = {24'd0, o_laneSel1, o_laneSel0};
      end
      REG_STATUS: begin
        rdData = {20'd0, i_wrPtr, 5'd0, i_wrapped, i_state};
      end
      REG_TSTAMP: begin
        rdData = {{(APB_DATA_WIDTH-TSTAMP_WIDTH){1'b0}}, i_tstamp};
      end
      default: begin
        regHit = 1'b0;
        if (bufHit) begin
          rdData = i_bufData;
        end
      end
    endcase
  end

  always_comb begin
    o_prdata  = '0;
    o_pslverr = 1'b0;
    if (access) begin
      if (!i_pwrite) begin
        o_prdata = rdData;
      end
      // Unmapped, or a write to a read-only location
      if (!(regHit || bufHit) || (i_pwrite && !regWritable)) begin
        o_pslverr = 1'b1;
      end
    end
  end

  // ************************************************************
  // Writable registers, updated at the access edge
  // ************************************************************
  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      o_enable   <= 1'b0;
      o_wrapMode <= 1'b0;
      o_laneSel0 <= '0;
      o_laneSel1 <= '0;
    end else if (access && i_pwrite) begin
      if (i_paddr == REG_CTRL) begin
        o_enable   <= i_pwdata[0];
        o_wrapMode <= i_pwdata[1];
      end
      if (i_paddr == REG_MUXSEL) begin
        o_laneSel0 <= i_pwdata[3:0];
        o_laneSel1 <= i_pwdata[7:4];
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/dstTop.sv
// Debug signal trace unit top level
`timescale 1ns/1ps
`default_nettype none

module dstTop import dstPkg::*; (
  input  logic                                       i_clk,
  input  logic                                       i_rstN,
  input  logic [NUM_HW_WORDS-1:0][HW_WORD_WIDTH-1:0] i_hw,
  input  logic                                       i_timeTick,
  input  logic                                       i_traceStart,
  input  logic                                       i_traceStop,
  input  logic                                       i_tracePulse,
  // APB
  input  logic [APB_ADDR_WIDTH-1:0]                  i_paddr,
  input  logic                                       i_psel,
  input  logic                                       i_penable,
  input  logic                                       i_pwrite,
  input  logic [APB_DATA_WIDTH-1:0]                  i_pwdata,
  output logic                                       o_pready,
  output logic [APB_DATA_WIDTH-1:0]                  o_prdata,
  output logic                                       o_pslverr
);

  logic                       enable;
  logic                       wrapMode;
  logic [LANE_SEL_WIDTH-1:0]  laneSel0;
  logic [LANE_SEL_WIDTH-1:0]  laneSel1;
  logic [DEBUG_BUS_WIDTH-1:0] debugBus;
  logic                       busChanged;
  traceState_e                state;
  logic                       capture;
  logic                       clear;
  logic [TSTAMP_WIDTH-1:0]    tstamp;
  logic [PTR_WIDTH-1:0]       wrPtr;
  logic                       wrapped;
  logic [APB_DATA_WIDTH-1:0]  bufData;
  logic [PTR_WIDTH-1:0]       bufRdIdx;
  logic                       bufRdHalf;

  dstRegs uRegs (
    .i_clk(i_clk), .i_rstN(i_rstN),
    .i_paddr(i_paddr), .i_psel(i_psel), .i_penable(i_penable),
    .i_pwrite(i_pwrite), .i_pwdata(i_pwdata),
    .i_state(state), .i_wrPtr(wrPtr), .i_wrapped(wrapped),
    .i_tstamp(tstamp), .i_bufData(bufData),
    .o_pready(o_pready), .o_prdata(o_prdata), .o_pslverr(o_pslverr),
    .o_enable(enable), .o_wrapMode(wrapMode),
    .o_laneSel0(laneSel0), .o_laneSel1(laneSel1),
    .o_bufRdIdx(bufRdIdx), .o_bufRdHalf(bufRdHalf)
  );

  dbgMuxSel uMuxSel (
    .i_clk(i_clk), .i_rstN(i_rstN), .i_hw(i_hw),
    .i_laneSel0(laneSel0), .i_laneSel1(laneSel1),
    .o_debugBus(debugBus), .o_busChanged(busChanged)
  );

  traceCtrl uCtrl (
    .i_clk(i_clk), .i_rstN(i_rstN), .i_enable(enable), .i_wrapMode(wrapMode),
    .i_traceStart(i_traceStart), .i_traceStop(i_traceStop),
    .i_tracePulse(i_tracePulse), .i_busChanged(busChanged), .i_wrapped(wrapped),
    .o_state(state), .o_capture(capture), .o_clear(clear)
  );

  timestampCounter uTstamp (
    .i_clk(i_clk), .i_rstN(i_rstN), .i_timeTick(i_timeTick),
    .i_clear(clear), .o_tstamp(tstamp)
  );

  traceBuffer uBuffer (
    .i_clk(i_clk), .i_rstN(i_rstN), .i_capture(capture), .i_clear(clear),
    .i_debugBus(debugBus), .i_tstamp(tstamp),
    .i_rdIdx(bufRdIdx), .i_rdHalf(bufRdHalf),
    .o_wrPtr(wrPtr), .o_wrapped(wrapped), .o_rdData(bufData)
  );

endmodule

`default_nettype wire

//--- verilog/timestampCounter.sv
// Time tick counter for trace timestamps
`timescale 1ns/1ps
`default_nettype none

module timestampCounter import dstPkg::*; (
  input  logic                    i_clk,
  input  logic                    i_rstN,
  input  logic                    i_timeTick,
  input  logic                    i_clear,
  output logic [TSTAMP_WIDTH-1:0] o_tstamp
);

  logic [TSTAMP_WIDTH-1:0] count;

  // Rolls over, clear takes priority over a tick
  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      count <= '0;
    end else if (i_clear) begin
      count <= '0;
    end else if (i_timeTick) begin
      count <= count + 1'b1;
    end
  end

  assign o_tstamp = count;

endmodule

`default_nettype wire

//--- verilog/traceBuffer.sv
// Trace entry storage with write pointer, wrap flag and read port
`timescale 1ns/1ps
`default_nettype none

module traceBuffer import dstPkg::*; (
  input  logic                       i_clk,
  input  logic                       i_rstN,
  input  logic                       i_capture,
  input  logic                       i_clear,
  input  logic [DEBUG_BUS_WIDTH-1:0] i_debugBus,
  input  logic [TSTAMP_WIDTH-1:0]    i_tstamp,
  input  logic [PTR_WIDTH-1:0]       i_rdIdx,
  input  logic                       i_rdHalf,
  output logic [PTR_WIDTH-1:0]       o_wrPtr,
  output logic                       o_wrapped,
  output logic [APB_DATA_WIDTH-1:0]  o_rdData
);

  logic [DEBUG_BUS_WIDTH-1:0] dataMem [TRACE_DEPTH];
  logic [TSTAMP_WIDTH-1:0]    tsMem   [TRACE_DEPTH];
  logic [PTR_WIDTH-1:0]       wrPtr;
  logic                       wrapped;
  logic                       doWrite;

  // A clear in the same cycle wins over a capture
  assign doWrite = i_capture && !i_clear;

  // ************************************************************
  // Pointer and wrap flag
  // ************************************************************
  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      wrPtr   <= '0;
      wrapped <= 1'b0;
    end else if (i_clear) begin
      wrPtr   <= '0;
      wrapped <= 1'b0;
    end else if (doWrite) begin
      wrPtr <= wrPtr + 1'b1;
      // Last slot written, sticky until the next clear
      if (wrPtr == PTR_WIDTH'(TRACE_DEPTH - 1)) begin
        wrapped <= 1'b1;
      end
    end
  end

  // Entry storage
  always_ff @(posedge i_clk) begin
    if (doWrite) begin
      dataMem[wrPtr] <= i_debugBus;
      tsMem[wrPtr]   <= i_tstamp;
    end
  end

  assign o_wrPtr   = wrPtr;
  assign o_wrapped = wrapped;

  // Upper half of an entry holds the timestamp
  always_comb begin
    if (i_rdHalf) begin
      o_rdData = {{(APB_DATA_WIDTH-TSTAMP_WIDTH){1'b0}}, tsMem[i_rdIdx]};
    end else begin
      o_rdData = dataMem[i_rdIdx];
    end
  end

endmodule

`default_nettype wire

//--- verilog/traceCtrl.sv
// Trace state machine with capture and clear strobes
`timescale 1ns/1ps
`default_nettype none

module traceCtrl import dstPkg::*; (
  input  logic        i_clk,
  input  logic        i_rstN,
  input  logic        i_enable,
  input  logic        i_wrapMode,
  input  logic        i_traceStart,
  input  logic        i_traceStop,
  input  logic        i_tracePulse,
  input  logic        i_busChanged,
  input  logic        i_wrapped,
  output traceState_e o_state,
  output logic        o_capture,
  output logic        o_clear
);

  traceState_e state;
  traceState_e nextState;
  logic        firstTraceQ;
  logic        bufOpen;

  // ************************************************************
  // State machine
  // ************************************************************
  always_comb begin
    nextState = state;
    if (!i_enable) begin
      nextState = ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:    nextState = ST_ARMED;
        ST_ARMED:   if (i_traceStart) nextState = ST_TRACING;
        ST_TRACING: begin
          if (i_traceStop) begin
            nextState = ST_ARMED;
          end else if (!i_wrapMode && i_wrapped) begin
            nextState = ST_FULL;
          end
        end
        ST_FULL:    if (i_traceStop) nextState = ST_ARMED;
        default:    nextState = ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      state       <= ST_IDLE;
      firstTraceQ <= 1'b0;
    end else begin
      state       <= nextState;
      firstTraceQ <= o_clear;
    end
  end

  assign o_state = state;

  // Start seen while armed restarts pointer and timestamp
  assign o_clear = i_enable && (state == ST_ARMED) && i_traceStart;

  // Full buffer takes no more entries unless wrapping
  assign bufOpen = i_wrapMode || !i_wrapped;

  assign o_capture = bufOpen &&
                     (((state == ST_TRACING) && (firstTraceQ || i_busChanged)) ||
                      (i_tracePulse && ((state == ST_ARMED) || (state == ST_TRACING))));

endmodule

`default_nettype wire
